// File: all.f
rv_pkg.sv
pipe_control.sv
reg_file.sv
imm_gen.sv
exec_unit.sv
mem_wb_stage.sv
core_top.sv
core_tb.sv

// File: Makefile
TOP := core_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f all.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf obj_dir

// File: core_tb.sv
`timescale 1ns/1ps

module core_tb;
    import rv_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int RST_CYCLES = 16;
    localparam int N_TESTS    = 6;
    localparam int TEST_LEN [N_TESTS] = '{20, 40, 40, 40, 150, 40}; // cycle budget per test

    // instruction formats the stimulus can build
    typedef enum logic [3:0] {
        K_R, K_I, K_LUI, K_AUIPC, K_JAL, K_JALR, K_BR, K_LW, K_SW
    } kind_e;

    // expected results of one issued instruction
    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        word_t     wdata;
        logic      jump;
        word_t     target;
        logic [2:0] tid;   // owning test
    } exp_t;

    logic      clk = 1'b0;
    logic      rst_n;
    instr_t    instr;
    word_t     pc;
    logic      jump, rf_we;
    word_t     jump_target, rf_wdata;
    reg_addr_t rf_waddr;

    integer     seed = 32'h1f51_600d;
    word_t      regs_m [32] = '{default: '0}; // architectural model
    word_t      dmem_m [DMEM_WORDS] = '{default: '0};
    word_t      pc_next = 32'h0000_1000;
    logic [2:0] cur_tid = 3'd0;
    int         err_cnt [N_TESTS] = '{default: 0};
    string      test_name [N_TESTS] = '{"reset_nops", "alu_ops", "forwarding",
                                        "store_load", "branches", "jumps"};
    exp_t       exp_id = '0; // one entry per stage, shifted on every issue
    exp_t       exp_ex = '0;
    exp_t       exp_mem = '0;
    exp_t       exp_wb = '0;

    core_top uut (
        .clk(clk), .rst_n(rst_n), .instr(instr), .pc(pc), .jump(jump),
        .jump_target(jump_target), .rf_we(rf_we), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    //////////////////////////////////////////////////
    // checks against the expected pipeline
    //////////////////////////////////////////////////
    function automatic void log_mismatch(input logic [2:0] tid, input string what,
                                         input word_t exp_v, input word_t act_v);
        err_cnt[tid]++;
        $display("mismatch %s %s expected %h actual %h", test_name[tid], what, exp_v, act_v);
    endfunction

    a_jump: assert property (@(posedge clk) disable iff (!rst_n) jump == exp_mem.jump)
        else log_mismatch($sampled(exp_mem.tid), "jump",
                          {31'd0, $sampled(exp_mem.jump)}, {31'd0, $sampled(jump)});
    a_target: assert property (@(posedge clk) disable iff (!rst_n)
        exp_mem.jump |-> jump_target == exp_mem.target)
        else log_mismatch($sampled(exp_mem.tid), "jump_target",
                          $sampled(exp_mem.target), $sampled(jump_target));
    a_we: assert property (@(posedge clk) disable iff (!rst_n) rf_we == exp_wb.we)
        else log_mismatch($sampled(exp_wb.tid), "rf_we",
                          {31'd0, $sampled(exp_wb.we)}, {31'd0, $sampled(rf_we)});
    a_waddr: assert property (@(posedge clk) disable iff (!rst_n)
        exp_wb.we |-> rf_waddr == exp_wb.waddr)
        else log_mismatch($sampled(exp_wb.tid), "rf_waddr",
                          {27'd0, $sampled(exp_wb.waddr)}, {27'd0, $sampled(rf_waddr)});
    a_wdata: assert property (@(posedge clk) disable iff (!rst_n)
        exp_wb.we |-> rf_wdata == exp_wb.wdata)
        else log_mismatch($sampled(exp_wb.tid), "rf_wdata",
                          $sampled(exp_wb.wdata), $sampled(rf_wdata));

    //////////////////////////////////////////////////
    // reference model, straight from the isa
    //////////////////////////////////////////////////
    function automatic word_t rnd();
        return $random(seed);
    endfunction

    function automatic word_t sext12(input word_t v);
        return {{20{v[11]}}, v[11:0]};
    endfunction

    function automatic word_t model_alu(input logic [2:0] f3, input logic alt,
                                        input word_t a, input word_t b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input word_t a, input word_t b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b; // bgeu
        endcase
    endfunction

    function automatic instr_t encode(input kind_e k, input logic [2:0] f3, input logic alt,
                                      input reg_addr_t rd, input reg_addr_t rs1,
                                      input reg_addr_t rs2, input word_t imm);
        logic [6:0] f7;
        f7 = alt ? 7'h20 : 7'h00;
        case (k)
            K_R:     return {f7, rs2, rs1, f3, rd, 7'b0110011};
            K_I:     return (f3 == 3'd1 || f3 == 3'd5) ? {f7, imm[4:0], rs1, f3, rd, 7'b0010011}
                                                       : {imm[11:0], rs1, f3, rd, 7'b0010011};
            K_LUI:   return {imm[31:12], rd, 7'b0110111};
            K_AUIPC: return {imm[31:12], rd, 7'b0010111};
            K_JAL:   return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
            K_JALR:  return {imm[11:0], rs1, 3'b000, rd, 7'b1100111};
            K_BR:    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
            K_LW:    return {imm[11:0], rs1, 3'b010, rd, 7'b0000011};
            default: return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011}; // sw
        endcase
    endfunction

    // run the model, then drive one instruction on the next edge
    task automatic issue(input kind_e k, input logic [2:0] f3, input logic alt,
                         input reg_addr_t rd, input reg_addr_t rs1, input reg_addr_t rs2,
                         input word_t imm);
        exp_t  e;
        word_t a, b, res, addr;
        logic  wr;
        a     = regs_m[rs1];
        b     = regs_m[rs2];
        addr  = a + imm;
        e     = '0;
        e.tid = cur_tid;
        res   = '0;
        wr    = 1'b1;
        case (k)
            K_R:     res = model_alu(f3, alt, a, b);
            K_I:     res = model_alu(f3, alt, a, imm);
            K_LUI:   res = {imm[31:12], 12'd0};
            K_AUIPC: res = pc_next + {imm[31:12], 12'd0};
            K_LW:    res = dmem_m[addr[7:2]];
            K_SW: begin
                dmem_m[addr[7:2]] = b;
                wr                = 1'b0;
            end
            K_BR: begin
                e.jump   = branch_taken(f3, a, b);
                e.target = pc_next + imm;
                wr       = 1'b0;
            end
            default: begin // jal, jalr
                res      = pc_next + 32'd4;
                e.jump   = 1'b1;
                e.target = (k == K_JAL) ? pc_next + imm : a + imm;
            end
        endcase
        if (wr && rd != 5'd0) begin // x0 never shows on rf_we
            regs_m[rd] = res;
            e.we       = 1'b1;
            e.waddr    = rd;
            e.wdata    = res;
        end
        @(posedge clk);
        instr   <= encode(k, f3, alt, rd, rs1, rs2, imm);
        pc      <= pc_next;
        exp_id  <= e;
        exp_ex  <= exp_id;
        exp_mem <= exp_ex;
        exp_wb  <= exp_mem;
        pc_next = pc_next + 32'd4;
    endtask

    task automatic issue_nops(input int n);
        repeat (n) issue(K_I, 3'd0, 1'b0, 5'd0, 5'd0, 5'd0, '0);
    endtask

    // lui then an addi that reads rd at distance 1
    task automatic load_random(input reg_addr_t rd);
        word_t v;
        v = rnd();
        issue(K_LUI, 3'd0, 1'b0, rd, 5'd0, 5'd0, v);
        issue(K_I, 3'd0, 1'b0, rd, rd, 5'd0, sext12(v));
    endtask

    //////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////
    task automatic run_alu_ops();
        word_t r;
        load_random(5'd1);
        load_random(5'd2);
        for (int f = 0; f < 8; f++) begin
            r = rnd();
            issue(K_R, f[2:0], 1'b0, reg_addr_t'(f + 3), 5'd1, 5'd2, '0);
            if (f == 0 || f == 5)
                issue(K_R, f[2:0], 1'b1, reg_addr_t'(f + 11), 5'd1, 5'd2, '0); // sub, sra
            if (f == 1 || f == 5)
                issue(K_I, f[2:0], f == 5 && r[5], reg_addr_t'(f + 18), 5'd1, 5'd0,
                      {27'd0, r[4:0]}); // shamt
            else
                issue(K_I, f[2:0], 1'b0, reg_addr_t'(f + 18), 5'd1, 5'd0, sext12(r));
        end
        issue(K_R, 3'd0, 1'b0, 5'd0, 5'd1, 5'd2, '0); // x0 dest writes nothing
        issue(K_I, 3'd4, 1'b0, 5'd0, 5'd1, 5'd0, sext12(rnd()));
        issue(K_LUI, 3'd0, 1'b0, 5'd10, 5'd0, 5'd0, rnd());
        issue(K_AUIPC, 3'd0, 1'b0, 5'd11, 5'd0, 5'd0, rnd());
    endtask

    task automatic run_forwarding();
        load_random(5'd1);
        load_random(5'd2);
        for (int d = 1; d <= 3; d++) begin
            for (int side = 0; side < 2; side++) begin
                issue(K_I, 3'd0, 1'b0, 5'd12, 5'd12, 5'd0, sext12(rnd())); // fresh x12
                issue_nops(d - 1);
                if (side == 0)
                    issue(K_R, 3'd0, 1'b1, 5'd13, 5'd12, 5'd2, '0); // via rs1
                else
                    issue(K_R, 3'd0, 1'b1, 5'd13, 5'd1, 5'd12, '0); // via rs2
            end
        end
    endtask

    task automatic run_store_load();
        issue(K_I, 3'd0, 1'b0, 5'd5, 5'd0, 5'd0, 32'h40); // base address
        for (int k = 0; k < 4; k++) begin
            load_random(5'd6);                                     // store data from mem stage
            issue(K_SW, 3'd2, 1'b0, 5'd0, 5'd5, 5'd6, word_t'(k * 4));
            issue(K_LW, 3'd2, 1'b0, 5'd7, 5'd5, 5'd0, word_t'(k * 4));
            issue_nops(1);                                         // load-use gap
            issue(K_R, 3'd0, 1'b0, 5'd8, 5'd7, 5'd0, '0);
        end
        for (int k = 0; k < 4; k++)
            issue(K_LW, 3'd2, 1'b0, 5'd9, 5'd5, 5'd0, word_t'(k * 4)); // read back
    endtask

    task automatic run_branches();
        word_t      r;
        logic [2:0] f3;
        for (int b = 0; b < 6; b++) begin
            f3 = (b < 2) ? 3'(b) : 3'(b + 2); // beq bne blt bge bltu bgeu
            for (int rep = 0; rep < 3; rep++) begin
                r = rnd();
                load_random(5'd1);
                if (rep == 0)
                    issue(K_R, 3'd0, 1'b0, 5'd2, 5'd1, 5'd0, '0); // equal operands
                else
                    load_random(5'd2);
                issue(K_BR, f3, 1'b0, 5'd0, 5'd1, 5'd2, {{19{r[12]}}, r[12:1], 1'b0});
                issue_nops(2);
            end
        end
    endtask

    task automatic run_jumps();
        word_t r;
        for (int j = 0; j < 3; j++) begin
            r = rnd();
            issue(K_JAL, 3'd0, 1'b0, 5'd15, 5'd0, 5'd0, {{11{r[20]}}, r[20:1], 1'b0});
            issue_nops(2);
            // link register read back at distance 3
            issue(K_JALR, 3'd0, 1'b0, 5'd16, 5'd15, 5'd0, {{20{r[31]}}, r[31:22], 2'b00});
            issue_nops(2);
        end
        issue(K_JAL, 3'd0, 1'b0, 5'd0, 5'd0, 5'd0, 32'h100); // no link
        issue_nops(2);
    endtask

    //////////////////////////////////////////////////
    // sequencing and summary
    //////////////////////////////////////////////////
    initial begin
        int total_err;
        int failed;
        rst_n     = 1'b0;
        instr     = NOP_INSTR;
        pc        = '0;
        total_err = 0;
        failed    = 0;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        for (int t = 0; t < N_TESTS; t++) begin
            cur_tid = t[2:0];
            case (t)
                0:       issue_nops(8);
                1:       run_alu_ops();
                2:       run_forwarding();
                3:       run_store_load();
                4:       run_branches();
                default: run_jumps();
            endcase
            issue_nops(5); // last writeback checked before the report
            @(negedge clk); // assertions of the last edge have reported
            $display("test %0d %-11s %s, %0d errors", t, test_name[t],
                     (err_cnt[t] == 0) ? "ok" : "FAILED", err_cnt[t]);
        end
        for (int t = 0; t < N_TESTS; t++) begin
            total_err += err_cnt[t];
            if (err_cnt[t] != 0)
                failed++;
        end
        $display("tests run %0d, tests failed %0d, errors %0d", N_TESTS, failed, total_err);
        if (total_err == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

    // watchdog sized from the test budgets
    initial begin
        int budget;
        budget = RST_CYCLES + 50;
        for (int i = 0; i < N_TESTS; i++)
            budget += TEST_LEN[i];
        #(budget * CLK_PERIOD);
        $display("watchdog timeout, tests did not finish within %0d cycles", budget);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: core_top.sv
`timescale 1ns/1ps

module core_top (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::instr_t    instr,
    input  rv_pkg::word_t     pc,
    output logic              jump,
    output rv_pkg::word_t     jump_target,
    output logic              rf_we,
    output rv_pkg::reg_addr_t rf_waddr,
    output rv_pkg::word_t     rf_wdata
);
    import rv_pkg::*;

    imm_sel_e imm_sel;
    ex_ctrl_t ex_ctrl;
    fwd_t     fwd;
    wb_sel_e  wb_sel;
    logic     dmem_we, br_eq, br_lt;
    word_t    rdata1, rdata2, imm;
    word_t    alu_mem, store_mem, pc4_mem;

    assign jump_target = alu_mem; // mem stage target

    pipe_control u_ctrl (
        .clk(clk), .rst_n(rst_n), .instr(instr), .br_eq(br_eq), .br_lt(br_lt),
        .imm_sel(imm_sel), .ex_ctrl(ex_ctrl), .fwd(fwd), .dmem_we(dmem_we),
        .wb_sel(wb_sel), .rf_we(rf_we), .rf_waddr(rf_waddr), .jump(jump)
    );

    // decode stage reads
    reg_file u_rf (
        .clk(clk), .rst_n(rst_n), .raddr1(instr[19:15]), .raddr2(instr[24:20]),
        .we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata),
        .rdata1(rdata1), .rdata2(rdata2)
    );

    imm_gen u_imm (.instr(instr), .imm_sel(imm_sel), .imm(imm));

    exec_unit u_ex (
        .clk(clk), .rst_n(rst_n), .pc(pc), .rdata1(rdata1), .rdata2(rdata2),
        .imm(imm), .ex_ctrl(ex_ctrl), .fwd(fwd), .wb_data(rf_wdata),
        .br_eq(br_eq), .br_lt(br_lt), .alu_mem(alu_mem), .store_mem(store_mem),
        .pc4_mem(pc4_mem)
    );

    mem_wb_stage u_mem (
        .clk(clk), .rst_n(rst_n), .alu_mem(alu_mem), .store_mem(store_mem),
        .pc4_mem(pc4_mem), .dmem_we(dmem_we), .wb_sel(wb_sel), .rf_wdata(rf_wdata)
    );

endmodule

// File: mem_wb_stage.sv
`timescale 1ns/1ps

module mem_wb_stage (
    input  logic            clk,
    input  logic            rst_n,
    input  rv_pkg::word_t   alu_mem,   // address or result
    input  rv_pkg::word_t   store_mem,
    input  rv_pkg::word_t   pc4_mem,
    input  logic            dmem_we,
    input  rv_pkg::wb_sel_e wb_sel,    // wb stage select
    output rv_pkg::word_t   rf_wdata
);
    import rv_pkg::*;

    word_t               dmem [DMEM_WORDS];
    logic  [DMEM_AW-1:0] dmem_idx;
    word_t               load_wb, alu_wb, pc4_wb;

    assign dmem_idx = alu_mem[DMEM_AW+1:2]; // word index

    // store lands at end of mem stage
    always_ff @(posedge clk) begin
        if (dmem_we)
            dmem[dmem_idx] <= store_mem;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_wb <= '0;
            alu_wb  <= '0;
            pc4_wb  <= '0;
        end else begin
            load_wb <= dmem[dmem_idx]; // async read
            alu_wb  <= alu_mem;
            pc4_wb  <= pc4_mem;
        end
    end

    always_comb begin
        case (wb_sel)
            WB_MEM:  rf_wdata = load_wb;
            WB_ALU:  rf_wdata = alu_wb;
            WB_PC4:  rf_wdata = pc4_wb;
            default: rf_wdata = '0; // no write
        endcase
    end

    a_store_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_we |-> alu_mem[1:0] == 2'b00);

endmodule

// File: exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
    input  logic             clk,
    input  logic             rst_n,
    input  rv_pkg::word_t    pc,      // decode stage pc
    input  rv_pkg::word_t    rdata1,
    input  rv_pkg::word_t    rdata2,
    input  rv_pkg::word_t    imm,
    input  rv_pkg::ex_ctrl_t ex_ctrl,
    input  rv_pkg::fwd_t     fwd,
    input  rv_pkg::word_t    wb_data, // writeback result
    output logic             br_eq,
    output logic             br_lt,
    output rv_pkg::word_t    alu_mem,
    output rv_pkg::word_t    store_mem,
    output rv_pkg::word_t    pc4_mem
);
    import rv_pkg::*;

    word_t pc_ex, rs1_ex, rs2_ex, imm_ex;
    word_t rs1_fwd, rs2_fwd, store_fwd;
    word_t op_a, op_b, alu_y;

    function automatic word_t fwd_mux(input fwd_sel_e sel, input word_t reg_val);
        case (sel)
            FWD_MEM: return alu_mem;
            FWD_WB:  return wb_data;
            default: return reg_val;
        endcase
    endfunction

    ////////////////////////////////////////////////
    // decode to execute
    ////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_ex  <= '0;
            rs1_ex <= '0;
            rs2_ex <= '0;
            imm_ex <= '0;
        end else begin
            pc_ex  <= pc;
            rs1_ex <= rdata1;
            rs2_ex <= rdata2;
            imm_ex <= imm;
        end
    end

    assign rs1_fwd   = fwd_mux(fwd.fwd_a, rs1_ex);
    assign rs2_fwd   = fwd_mux(fwd.fwd_b, rs2_ex);
    assign store_fwd = fwd_mux(fwd.fwd_store, rs2_ex);

    assign op_a = ex_ctrl.a_sel ? pc_ex : rs1_fwd;
    assign op_b = ex_ctrl.b_sel ? imm_ex : rs2_fwd;

    always_comb begin
        case (ex_ctrl.alu_op)
            ALU_SUB:    alu_y = op_a - op_b;
            ALU_AND:    alu_y = op_a & op_b;
            ALU_OR:     alu_y = op_a | op_b;
            ALU_XOR:    alu_y = op_a ^ op_b;
            ALU_SLL:    alu_y = op_a << op_b[4:0];
            ALU_SRL:    alu_y = op_a >> op_b[4:0];
            ALU_SRA:    alu_y = word_t'($signed(op_a) >>> op_b[4:0]);
            ALU_SLTU:   alu_y = {31'd0, op_a < op_b};
            ALU_SLT:    alu_y = {31'd0, $signed(op_a) < $signed(op_b)};
            ALU_PASS_B: alu_y = op_b; // lui
            default:    alu_y = op_a + op_b;
        endcase
    end

    // comparator sees forwarded regs, not alu inputs
    assign br_eq = (rs1_fwd == rs2_fwd);
    assign br_lt = ex_ctrl.branch_signed ? ($signed(rs1_fwd) < $signed(rs2_fwd))
                                         : (rs1_fwd < rs2_fwd);

    ////////////////////////////////////////////////
    // execute to memory
    ////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alu_mem   <= '0;
            store_mem <= '0;
            pc4_mem   <= '0;
        end else begin
            alu_mem   <= alu_y;
            store_mem <= store_fwd;
            pc4_mem   <= pc_ex + 32'd4; // link value
        end
    end

endmodule

// File: imm_gen.sv
`timescale 1ns/1ps

module imm_gen (
    input  rv_pkg::instr_t   instr,
    input  rv_pkg::imm_sel_e imm_sel,
    output rv_pkg::word_t    imm
);
    import rv_pkg::*;

    logic sgn; // sign bit of every format

    assign sgn = instr[31];

    always_comb begin
        case (imm_sel)
            IMM_I:       imm = {{20{sgn}}, instr[31:20]};
            IMM_I_SHIFT: imm = {27'd0, instr[24:20]}; // shamt only
            IMM_S:       imm = {{20{sgn}}, instr[31:25], instr[11:7]};
            // branch offset, bit 0 implied
            IMM_B: begin
                imm = {{19{sgn}}, sgn, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            IMM_U:       imm = {instr[31:12], 12'd0};
            // jal offset, scrambled fields
            IMM_J: begin
                imm = {{11{sgn}}, sgn, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default:     imm = '0;
        endcase
    end

endmodule

// File: reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::reg_addr_t raddr1,
    input  rv_pkg::reg_addr_t raddr2,
    input  logic              we,
    input  rv_pkg::reg_addr_t waddr,
    input  rv_pkg::word_t     wdata,
    output rv_pkg::word_t     rdata1,
    output rv_pkg::word_t     rdata2
);
    import rv_pkg::*;

    word_t regs [32]; // x0 entry never written

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // write-first bypass covers the distance-3 hazard
    assign rdata1 = (we && waddr != '0 && waddr == raddr1) ? wdata : regs[raddr1];
    assign rdata2 = (we && waddr != '0 && waddr == raddr2) ? wdata : regs[raddr2];

    a_x0_rd1: assert property (@(posedge clk) disable iff (!rst_n)
        raddr1 == '0 |-> rdata1 == '0);
    a_x0_rd2: assert property (@(posedge clk) disable iff (!rst_n)
        raddr2 == '0 |-> rdata2 == '0);

endmodule

// File: pipe_control.sv
`timescale 1ns/1ps

module pipe_control (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::instr_t    instr,   // decode stage
    input  logic              br_eq,   // from execute
    input  logic              br_lt,
    output rv_pkg::imm_sel_e  imm_sel,
    output rv_pkg::ex_ctrl_t  ex_ctrl,
    output rv_pkg::fwd_t      fwd,
    output logic              dmem_we,
    output rv_pkg::wb_sel_e   wb_sel,
    output logic              rf_we,
    output rv_pkg::reg_addr_t rf_waddr,
    output logic              jump
);
    import rv_pkg::*;

    instr_t    instr_ex, instr_mem, instr_wb; // per-stage copies
    logic      br_eq_mem, br_lt_mem;          // flags moved into mem
    logic      use_rs1, use_rs2;
    logic      we_mem, we_wb;
    reg_addr_t rd_mem, rd_wb;

    // opcodes per stage
    logic [4:0] opc_id, opc_ex, opc_mem, opc_wb;
    logic [2:0] f3_ex, f3_mem;

    assign opc_id  = instr[6:2];
    assign opc_ex  = instr_ex[6:2];
    assign opc_mem = instr_mem[6:2];
    assign opc_wb  = instr_wb[6:2];
    assign f3_ex   = instr_ex[14:12];
    assign f3_mem  = instr_mem[14:12];

    // true for every format that has rd
    function automatic logic writes_rd(input instr_t i);
        case (i[6:2])
            OPC_OP, OPC_OP_IMM, OPC_LOAD, OPC_JAL,
            OPC_JALR, OPC_AUIPC, OPC_LUI: return 1'b1;
            default:                      return 1'b0;
        endcase
    endfunction

    // shared by reg and imm arithmetic
    function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    // mem stage wins over wb
    function automatic fwd_sel_e fwd_pick(input reg_addr_t rs, input logic used);
        fwd_sel_e sel;
        sel = FWD_REG;
        if (used && rs != '0) begin
            if (we_mem && rd_mem == rs)
                sel = FWD_MEM;
            else if (we_wb && rd_wb == rs)
                sel = FWD_WB;
        end
        return sel;
    endfunction

    ////////////////////////////////////////////////
    // control pipeline
    ////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instr_ex  <= NOP_INSTR;
            instr_mem <= NOP_INSTR;
            instr_wb  <= NOP_INSTR;
            br_eq_mem <= 1'b0;
            br_lt_mem <= 1'b0;
        end else begin
            instr_ex  <= instr;
            instr_mem <= instr_ex;
            instr_wb  <= instr_mem;
            br_eq_mem <= br_eq;
            br_lt_mem <= br_lt;
        end
    end

    // decode stage, immediate kind
    always_comb begin
        case (opc_id)
            OPC_OP_IMM: imm_sel = (instr[13:12] == 2'b01) ? IMM_I_SHIFT : IMM_I; // slli/srli/srai
            OPC_STORE:  imm_sel = IMM_S;
            OPC_BRANCH: imm_sel = IMM_B;
            OPC_JAL:    imm_sel = IMM_J;
            OPC_AUIPC,
            OPC_LUI:    imm_sel = IMM_U;
            default:    imm_sel = IMM_I; // load, jalr, don't care
        endcase
    end

    // execute stage controls and register usage
    always_comb begin
        ex_ctrl = '{alu_op: ALU_ADD, a_sel: 1'b0, b_sel: 1'b0, branch_signed: 1'b1};
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        case (opc_ex)
            OPC_OP: begin
                ex_ctrl.alu_op = alu_decode(f3_ex, instr_ex[30]);
                use_rs1        = 1'b1;
                use_rs2        = 1'b1;
            end
            OPC_OP_IMM: begin
                // bit 30 only picks srai, never subi
                ex_ctrl.alu_op = alu_decode(f3_ex, instr_ex[30] && f3_ex == 3'b101);
                ex_ctrl.b_sel  = 1'b1;
                use_rs1        = 1'b1;
            end
            OPC_LOAD, OPC_JALR: begin
                ex_ctrl.b_sel = 1'b1; // rs1 + imm
                use_rs1       = 1'b1;
            end
            OPC_STORE: begin
                ex_ctrl.b_sel = 1'b1;
                use_rs1       = 1'b1;
                use_rs2       = 1'b1; // store data
            end
            OPC_BRANCH: begin
                ex_ctrl.a_sel         = 1'b1; // target pc + imm
                ex_ctrl.b_sel         = 1'b1;
                ex_ctrl.branch_signed = !f3_ex[1];
                use_rs1               = 1'b1;
                use_rs2               = 1'b1;
            end
            OPC_JAL, OPC_AUIPC: begin
                ex_ctrl.a_sel = 1'b1;
                ex_ctrl.b_sel = 1'b1;
            end
            OPC_LUI: begin
                ex_ctrl.alu_op = ALU_PASS_B;
                ex_ctrl.b_sel  = 1'b1;
            end
            default: ;
        endcase
    end

    ////////////////////////////////////////////////
    // forwarding
    ////////////////////////////////////////////////
    assign rd_mem = instr_mem[11:7];
    assign rd_wb  = instr_wb[11:7];
    assign we_mem = writes_rd(instr_mem) && rd_mem != '0;
    assign we_wb  = writes_rd(instr_wb) && rd_wb != '0;

    always_comb begin
        fwd.fwd_a     = fwd_pick(instr_ex[19:15], use_rs1);
        fwd.fwd_b     = FWD_REG;
        fwd.fwd_store = FWD_REG;
        if (opc_ex == OPC_STORE)
            fwd.fwd_store = fwd_pick(instr_ex[24:20], use_rs2); // data, not alu b
        else
            fwd.fwd_b = fwd_pick(instr_ex[24:20], use_rs2);
    end

    // memory stage
    assign dmem_we = (opc_mem == OPC_STORE);

    always_comb begin
        jump = 1'b0;
        case (opc_mem)
            OPC_JAL, OPC_JALR: jump = 1'b1;
            OPC_BRANCH: begin
                case (f3_mem)
                    3'b000:         jump = br_eq_mem;  // beq
                    3'b001:         jump = !br_eq_mem; // bne
                    3'b100, 3'b110: jump = br_lt_mem;  // blt, bltu
                    3'b101, 3'b111: jump = !br_lt_mem; // bge, bgeu
                    default:        jump = 1'b0;
                endcase
            end
            default: jump = 1'b0;
        endcase
    end

    // writeback stage
    always_comb begin
        case (opc_wb)
            OPC_LOAD:           wb_sel = WB_MEM;
            OPC_JAL, OPC_JALR:  wb_sel = WB_PC4;
            OPC_OP, OPC_OP_IMM,
            OPC_AUIPC, OPC_LUI: wb_sel = WB_ALU;
            default:            wb_sel = WB_NONE;
        endcase
    end

    assign rf_we    = we_wb; // x0 already masked
    assign rf_waddr = rd_wb;

    a_jump_known: assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(jump));
    a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
        rf_we |-> rf_waddr != '0);

endmodule

// File: rv_pkg.sv
package rv_pkg;

    ////////////////////////////////////////////////
    // basic vector types
    ////////////////////////////////////////////////
    typedef logic [31:0] word_t;     // data word or byte address
    typedef logic [31:0] instr_t;    // raw instruction
    typedef logic [4:0]  reg_addr_t; // register index

    // alu operation codes
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLL    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_SLTU   = 4'd8,
        ALU_SLT    = 4'd9,
        ALU_PASS_B = 4'd10 // lui
    } alu_op_e;

    typedef enum logic [2:0] {
        IMM_I, IMM_I_SHIFT, IMM_S, IMM_B, IMM_U, IMM_J
    } imm_sel_e;

    typedef enum logic [1:0] {
        WB_MEM, WB_ALU, WB_PC4, WB_NONE
    } wb_sel_e;

    typedef enum logic [1:0] {
        FWD_REG, FWD_WB, FWD_MEM
    } fwd_sel_e;

    typedef struct packed {
        alu_op_e alu_op;
        logic    a_sel;         // 1 = pc
        logic    b_sel;         // 1 = imm
        logic    branch_signed; // 0 for bltu/bgeu
    } ex_ctrl_t;

    typedef struct packed {
        fwd_sel_e fwd_a;
        fwd_sel_e fwd_b;
        fwd_sel_e fwd_store; // store data path
    } fwd_t;

    ////////////////////////////////////////////////
    // constants
    ////////////////////////////////////////////////
    localparam instr_t NOP_INSTR = 32'h0000_0013; // addi x0, x0, 0

    // major opcodes, instr[6:2]
    localparam logic [4:0] OPC_OP     = 5'b01100;
    localparam logic [4:0] OPC_OP_IMM = 5'b00100;
    localparam logic [4:0] OPC_LOAD   = 5'b00000;
    localparam logic [4:0] OPC_STORE  = 5'b01000;
    localparam logic [4:0] OPC_BRANCH = 5'b11000;
    localparam logic [4:0] OPC_JAL    = 5'b11011;
    localparam logic [4:0] OPC_JALR   = 5'b11001;
    localparam logic [4:0] OPC_AUIPC  = 5'b00101;
    localparam logic [4:0] OPC_LUI    = 5'b01101;

    localparam int DMEM_WORDS = 64;
    localparam int DMEM_AW    = $clog2(DMEM_WORDS); // word index bits

endpackage
